//--- sim.f
+incdir+include
verilog/rd_rob_pkg.sv
verilog/rob_ram.sv
verilog/rd_rob.sv
verilog/rd_rob_shim.sv
verilog/rd_rob_top.sv
verif/rd_rob_checker.sv
verif/rd_rob_tb.sv

//--- Makefile
# Verilator build and run of the read reorder shim testbench

VERILATOR ?= verilator
TOP       ?= rd_rob_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/rd_rob_tb.sv
// Testbench top: clock, reset, credit-limited request stimulus, out-of-order host model, timeout
`timescale 1ns/10ps
`include "rd_rob_cfg.svh"

module rd_rob_tb;
    import rd_rob_pkg::*;

    localparam int NUM_REQS = 300;

    // One outstanding line as the host sees it
    typedef struct packed {
        t_mdata tag;
        t_cl_num cl_num;
        t_line_addr addr;
    } t_host_beat;

    logic clk = 1'b0;
    logic reset;
    logic afu_req_valid;
    t_line_addr afu_req_addr;
    t_cl_num afu_req_cl_len;
    t_mdata afu_req_mdata;
    logic afu_credit_return;
    logic host_req_valid;
    t_line_addr host_req_addr;
    t_cl_num host_req_cl_len;
    t_mdata host_req_mdata;
    logic host_rsp_valid;
    t_rsp_type host_rsp_type;
    t_mdata host_rsp_mdata;
    t_cl_num host_rsp_cl_num;
    t_line_data host_rsp_data;
    logic afu_rsp_valid;
    t_rsp_type afu_rsp_type;
    t_mdata afu_rsp_mdata;
    t_cl_num afu_rsp_cl_num;
    t_line_data afu_rsp_data;

    logic end_of_run;
    logic final_done;
    int errors;

    integer seed;
    int credits;
    int total_beats;
    int timeout_limit;
    int cycles = 0;

    // Request list, made before the run so its length sets the timeout
    t_line_addr req_addr [NUM_REQS];
    t_cl_num req_len [NUM_REQS];
    t_mdata req_mdata [NUM_REQS];

    // Lines the host has accepted and not yet answered
    t_host_beat pending [$];

    always #10 clk = ~clk;

    rd_rob_top i_dut
    (
        .clk(clk),
        .reset(reset),
        .afu_req_valid(afu_req_valid),
        .afu_req_addr(afu_req_addr),
        .afu_req_cl_len(afu_req_cl_len),
        .afu_req_mdata(afu_req_mdata),
        .afu_credit_return(afu_credit_return),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_type(afu_rsp_type),
        .afu_rsp_mdata(afu_rsp_mdata),
        .afu_rsp_cl_num(afu_rsp_cl_num),
        .afu_rsp_data(afu_rsp_data),
        .host_req_valid(host_req_valid),
        .host_req_addr(host_req_addr),
        .host_req_cl_len(host_req_cl_len),
        .host_req_mdata(host_req_mdata),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp_type(host_rsp_type),
        .host_rsp_mdata(host_rsp_mdata),
        .host_rsp_cl_num(host_rsp_cl_num),
        .host_rsp_data(host_rsp_data)
    );

    // The checker sees every DUT port under the same name
    rd_rob_checker i_chk (.*);

    // ==================================================
    // Host memory contents
    // ==================================================

    // Every line address maps to its own data word
    function automatic t_line_data host_line_data(input t_line_addr addr);
        return t_line_data'({addr ^ t_line_addr'(32'h3c5a_a5c3), addr * t_line_addr'(32'h9e37_79b9)});
    endfunction

    // ==================================================
    // Stimulus tasks
    // ==================================================

    task automatic make_requests();
        total_beats = 0;
        for (int i = 0; i < NUM_REQS; i++)
        begin
            req_addr[i] = t_line_addr'($random(seed));
            req_len[i] = t_cl_num'($random(seed));
            req_mdata[i] = t_mdata'($random(seed));
            total_beats += int'(req_len[i]) + 1;
        end
    endtask

    // Issue the next request only while enough credits are held for all of its lines
    task automatic drive_request(inout int next_req);
        int lines;
        afu_req_valid = 1'b0;
        if (next_req < NUM_REQS)
        begin
            lines = int'(req_len[next_req]) + 1;
            if (credits >= lines && ($random(seed) & 3) != 0)
            begin
                afu_req_valid = 1'b1;
                afu_req_addr = req_addr[next_req];
                afu_req_cl_len = req_len[next_req];
                afu_req_mdata = req_mdata[next_req];
                credits -= lines;
                next_req++;
            end
        end
    endtask

    // The host answers any pending line at random, and now and then sends a message
    task automatic drive_response(input logic allow_msg);
        int pick;
        t_host_beat beat;
        host_rsp_valid = 1'b0;
        host_rsp_type = RSP_RDLINE;
        if (allow_msg && ($unsigned($random(seed)) % 12) == 0)
        begin
            host_rsp_valid = 1'b1;
            host_rsp_type = RSP_MSG;
            host_rsp_mdata = t_mdata'($random(seed));
            host_rsp_cl_num = t_cl_num'($random(seed));
            host_rsp_data = host_line_data(t_line_addr'($random(seed)));
        end
        else if (pending.size() > 0 && ($random(seed) & 7) != 0)
        begin
            pick = int'($unsigned($random(seed)) % pending.size());
            beat = pending[pick];
            pending.delete(pick);
            host_rsp_valid = 1'b1;
            host_rsp_mdata = beat.tag;
            host_rsp_cl_num = beat.cl_num;
            host_rsp_data = host_line_data(beat.addr);
        end
    endtask

    // Host capture and credit count, both read from stable mid-cycle values
    always @(negedge clk)
    begin
        t_host_beat beat;
        if (!reset)
        begin
            if (afu_credit_return)
            begin
                credits++;
            end
            if (host_req_valid)
            begin
                for (int k = 0; k <= int'(host_req_cl_len); k++)
                begin
                    beat.tag = host_req_mdata;
                    beat.cl_num = t_cl_num'(k);
                    beat.addr = host_req_addr + t_line_addr'(k);
                    pending.push_back(beat);
                end
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        int next_req;
        seed = 3;
        next_req = 0;
        reset = 1'b1;
        end_of_run = 1'b0;
        afu_req_valid = 1'b0;
        afu_req_addr = '0;
        afu_req_cl_len = '0;
        afu_req_mdata = '0;
        host_rsp_valid = 1'b0;
        host_rsp_type = RSP_RDLINE;
        host_rsp_mdata = '0;
        host_rsp_cl_num = '0;
        host_rsp_data = '0;
        credits = `RD_ROB_ENTRIES;
        make_requests();
        timeout_limit = 20 * total_beats;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Run until every request is out and every credit has come back
        while (next_req < NUM_REQS || credits != `RD_ROB_ENTRIES || pending.size() != 0)
        begin
            @(posedge clk);
            #1;
            drive_request(next_req);
            drive_response(1'b1);
        end

        @(posedge clk);
        #1;
        afu_req_valid = 1'b0;
        host_rsp_valid = 1'b0;

        // Let the last message leave the two-cycle bypass
        repeat (4) @(posedge clk);
        #1;
        end_of_run = 1'b1;
        wait (final_done);

        $display("Check failures: %0d", errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Bound on run length, scaled to the number of lines requested
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_limit)
        begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

endmodule

//--- verif/rd_rob_checker.sv
// Checker: reference data function, expected beat and message queues, comparisons, final balance
`timescale 1ns/10ps
`include "rd_rob_cfg.svh"

module rd_rob_checker
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    afu_req_valid,
    input  rd_rob_pkg::t_line_addr  afu_req_addr,
    input  rd_rob_pkg::t_cl_num     afu_req_cl_len,
    input  rd_rob_pkg::t_mdata      afu_req_mdata,
    input  logic                    afu_credit_return,
    input  logic                    host_req_valid,
    input  rd_rob_pkg::t_line_addr  host_req_addr,
    input  rd_rob_pkg::t_cl_num     host_req_cl_len,
    input  rd_rob_pkg::t_mdata      host_req_mdata,
    input  logic                    host_rsp_valid,
    input  rd_rob_pkg::t_rsp_type   host_rsp_type,
    input  rd_rob_pkg::t_mdata      host_rsp_mdata,
    input  rd_rob_pkg::t_cl_num     host_rsp_cl_num,
    input  rd_rob_pkg::t_line_data  host_rsp_data,
    input  logic                    afu_rsp_valid,
    input  rd_rob_pkg::t_rsp_type   afu_rsp_type,
    input  rd_rob_pkg::t_mdata      afu_rsp_mdata,
    input  rd_rob_pkg::t_cl_num     afu_rsp_cl_num,
    input  rd_rob_pkg::t_line_data  afu_rsp_data,

    // Final balance is taken once end_of_run is seen
    input  logic                    end_of_run,
    output int                      errors,
    output logic                    final_done
);
    import rd_rob_pkg::*;

    // One read beat the accelerator must still receive, in request order
    typedef struct packed {
        t_rob_idx idx;
        t_mdata mdata;
        t_cl_num cl_num;
        t_line_addr addr;
    } t_exp_beat;

    // One message seen on the host side, with its arrival cycle
    typedef struct packed {
        int arrival;
        t_mdata mdata;
        t_cl_num cl_num;
        t_line_data data;
    } t_exp_msg;

    t_exp_beat beats [$];
    t_exp_msg msgs [$];
    logic [`RD_ROB_ENTRIES-1:0] busy = '0;
    int err_count = 0;
    int cycle = 0;
    int spent = 0;
    int returned = 0;
    logic reset_window = 1'b0;
    logic done_flag = 1'b0;

    assign errors = err_count;
    assign final_done = done_flag;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Expected data of a line, from its address alone
    function automatic t_line_data ref_line_data(input t_line_addr addr);
        return t_line_data'({addr ^ t_line_addr'(32'h3c5a_a5c3), addr * t_line_addr'(32'h9e37_79b9)});
    endfunction

    task automatic compare(input string name, input t_line_data expected, input t_line_data actual);
        if (expected !== actual)
        begin
            err_count++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // ==================================================
    // Request side
    // ==================================================

    // Forwarding, tag range and overlap, and the expected beats of each request
    task automatic check_request();
        t_exp_beat e;
        compare("req_valid", t_line_data'(afu_req_valid), t_line_data'(host_req_valid));
        if (host_req_valid)
        begin
            compare("req_addr", t_line_data'(afu_req_addr), t_line_data'(host_req_addr));
            compare("req_cl_len", t_line_data'(afu_req_cl_len), t_line_data'(host_req_cl_len));
            if (host_req_mdata >= t_mdata'(`RD_ROB_ENTRIES))
            begin
                err_count++;
                $display("Host tag %0d lies outside the reorder buffer", host_req_mdata);
            end
            for (int k = 0; k <= int'(afu_req_cl_len); k++)
            begin
                e.idx = t_rob_idx'(host_req_mdata) + t_rob_idx'(k);
                e.mdata = afu_req_mdata;
                e.cl_num = t_cl_num'(k);
                e.addr = afu_req_addr + t_line_addr'(k);
                if (busy[e.idx])
                begin
                    err_count++;
                    $display("Host tag covers buffer line %0d, which is still outstanding", e.idx);
                end
                busy[e.idx] = 1'b1;
                beats.push_back(e);
            end
            spent += int'(afu_req_cl_len) + 1;
        end
    endtask

    // ==================================================
    // Response side
    // ==================================================

    // Read beats leave in request order with the original tag on every beat
    task automatic check_read_beat();
        t_exp_beat e;
        if (afu_rsp_valid && afu_rsp_type == RSP_RDLINE)
        begin
            if (beats.size() == 0)
            begin
                err_count++;
                $display("Read beat delivered at cycle %0d with no request outstanding", cycle);
            end
            else
            begin
                e = beats.pop_front();
                compare("read_cl_num", t_line_data'(e.cl_num), t_line_data'(afu_rsp_cl_num));
                compare("read_mdata", t_line_data'(e.mdata), t_line_data'(afu_rsp_mdata));
                compare("read_data", ref_line_data(e.addr), afu_rsp_data);
                busy[e.idx] = 1'b0;
            end
        end
    endtask

    // Messages come out unchanged, in order, two cycles after they arrive
    task automatic check_message();
        t_exp_msg m;
        if (msgs.size() > 0 && msgs[0].arrival + 2 < cycle)
        begin
            err_count++;
            $display("Message from cycle %0d never reached the accelerator", msgs[0].arrival);
            m = msgs.pop_front();
        end
        if (afu_rsp_valid && afu_rsp_type == RSP_MSG)
        begin
            if (msgs.size() == 0)
            begin
                err_count++;
                $display("Message delivered at cycle %0d with none pending", cycle);
            end
            else
            begin
                m = msgs.pop_front();
                compare("msg_cycle", t_line_data'(m.arrival + 2), t_line_data'(cycle));
                compare("msg_mdata", t_line_data'(m.mdata), t_line_data'(afu_rsp_mdata));
                compare("msg_cl_num", t_line_data'(m.cl_num), t_line_data'(afu_rsp_cl_num));
                compare("msg_data", m.data, afu_rsp_data);
            end
        end
    endtask

    task automatic log_message();
        t_exp_msg m;
        if (host_rsp_valid && host_rsp_type == RSP_MSG)
        begin
            m.arrival = cycle;
            m.mdata = host_rsp_mdata;
            m.cl_num = host_rsp_cl_num;
            m.data = host_rsp_data;
            msgs.push_back(m);
        end
    endtask

    // One credit per delivered read beat and none at any other time
    task automatic check_credit();
        if (afu_credit_return !== (afu_rsp_valid && afu_rsp_type == RSP_RDLINE))
        begin
            err_count++;
            $display("Credit return at cycle %0d does not match a read beat", cycle);
        end
        if (afu_credit_return)
        begin
            returned++;
        end
    endtask

    task automatic check_balance();
        compare("credit_balance", t_line_data'(spent), t_line_data'(returned));
        if (beats.size() != 0)
        begin
            err_count++;
            $display("%0d read beats were never delivered", beats.size());
        end
        if (msgs.size() != 0)
        begin
            err_count++;
            $display("%0d messages were never delivered", msgs.size());
        end
    endtask

    // ==================================================
    // Sampling
    // ==================================================

    // Everything is sampled mid-cycle, well away from the drive edge
    always @(negedge clk)
    begin
        // Outputs stay quiet through reset and the first cycle after it
        if (reset || reset_window)
        begin
            if (afu_rsp_valid || afu_credit_return)
            begin
                err_count++;
                $display("Response or credit active near reset at cycle %0d", cycle);
            end
        end
        reset_window = reset;
        if (!reset)
        begin
            check_request();
            check_read_beat();
            check_message();
            check_credit();
            log_message();
        end
        if (end_of_run && !done_flag)
        begin
            check_balance();
            done_flag = 1'b1;
        end
    end

endmodule

//--- verilog/rd_rob_top.sv
// Top level: accelerator and host ports around the read reorder shim
`timescale 1ns/10ps

module rd_rob_top
(
    input  logic                    clk,
    input  logic                    reset,

    // Accelerator side
    input  logic                    afu_req_valid,
    input  rd_rob_pkg::t_line_addr  afu_req_addr,
    input  rd_rob_pkg::t_cl_num     afu_req_cl_len,
    input  rd_rob_pkg::t_mdata      afu_req_mdata,
    output logic                    afu_credit_return,
    output logic                    afu_rsp_valid,
    output rd_rob_pkg::t_rsp_type   afu_rsp_type,
    output rd_rob_pkg::t_mdata      afu_rsp_mdata,
    output rd_rob_pkg::t_cl_num     afu_rsp_cl_num,
    output rd_rob_pkg::t_line_data  afu_rsp_data,

    // Host side
    output logic                    host_req_valid,
    output rd_rob_pkg::t_line_addr  host_req_addr,
    output rd_rob_pkg::t_cl_num     host_req_cl_len,
    output rd_rob_pkg::t_mdata      host_req_mdata,
    input  logic                    host_rsp_valid,
    input  rd_rob_pkg::t_rsp_type   host_rsp_type,
    input  rd_rob_pkg::t_mdata      host_rsp_mdata,
    input  rd_rob_pkg::t_cl_num     host_rsp_cl_num,
    input  rd_rob_pkg::t_line_data  host_rsp_data
);

    // All reordering and tagging happens inside the shim
    rd_rob_shim i_shim
    (
        .clk(clk),
        .reset(reset),
        .afu_req_valid(afu_req_valid),
        .afu_req_addr(afu_req_addr),
        .afu_req_cl_len(afu_req_cl_len),
        .afu_req_mdata(afu_req_mdata),
        .afu_credit_return(afu_credit_return),
        .host_req_valid(host_req_valid),
        .host_req_addr(host_req_addr),
        .host_req_cl_len(host_req_cl_len),
        .host_req_mdata(host_req_mdata),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp_type(host_rsp_type),
        .host_rsp_mdata(host_rsp_mdata),
        .host_rsp_cl_num(host_rsp_cl_num),
        .host_rsp_data(host_rsp_data),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_type(afu_rsp_type),
        .afu_rsp_mdata(afu_rsp_mdata),
        .afu_rsp_cl_num(afu_rsp_cl_num),
        .afu_rsp_data(afu_rsp_data)
    );

endmodule

//--- verilog/rd_rob_shim.sv
// Read reorder shim: request tagging, response capture, ordered dequeue, message merge, credits
`timescale 1ns/10ps

module rd_rob_shim
(
    input  logic                    clk,
    input  logic                    reset,

    // Accelerator requests
    input  logic                    afu_req_valid,
    input  rd_rob_pkg::t_line_addr  afu_req_addr,
    input  rd_rob_pkg::t_cl_num     afu_req_cl_len,
    input  rd_rob_pkg::t_mdata      afu_req_mdata,
    output logic                    afu_credit_return,

    // Requests toward the host
    output logic                    host_req_valid,
    output rd_rob_pkg::t_line_addr  host_req_addr,
    output rd_rob_pkg::t_cl_num     host_req_cl_len,
    output rd_rob_pkg::t_mdata      host_req_mdata,

    // Responses from the host, in any order
    input  logic                    host_rsp_valid,
    input  rd_rob_pkg::t_rsp_type   host_rsp_type,
    input  rd_rob_pkg::t_mdata      host_rsp_mdata,
    input  rd_rob_pkg::t_cl_num     host_rsp_cl_num,
    input  rd_rob_pkg::t_line_data  host_rsp_data,

    // Responses toward the accelerator, in request order
    output logic                    afu_rsp_valid,
    output rd_rob_pkg::t_rsp_type   afu_rsp_type,
    output rd_rob_pkg::t_mdata      afu_rsp_mdata,
    output rd_rob_pkg::t_cl_num     afu_rsp_cl_num,
    output rd_rob_pkg::t_line_data  afu_rsp_data
);
    import rd_rob_pkg::*;

    logic [2:0] alloc_n;
    t_rob_idx alloc_idx;
    logic enq_en;
    t_rob_idx enq_idx;
    t_line_data enq_data;
    logic deq_en;
    logic not_empty;
    t_line_data first_data;
    t_cl_num first_len;
    t_mdata first_mdata;

    // ==================================================
    // Request tagging
    // ==================================================

    // A request of cl_len+1 lines takes that many consecutive entries
    assign alloc_n = afu_req_valid ? {1'b0, afu_req_cl_len} + 3'd1 : 3'd0;

    // Requests go straight out, the host sees the base index as its tag
    // The accelerator's own tag waits in the metadata array
    assign host_req_valid = afu_req_valid;
    assign host_req_addr = afu_req_addr;
    assign host_req_cl_len = afu_req_cl_len;
    assign host_req_mdata = t_mdata'(alloc_idx);

    rd_rob i_rob
    (
        .clk(clk),
        .reset(reset),
        .alloc_n(alloc_n),
        .alloc_meta_len(afu_req_cl_len),
        .alloc_meta_mdata(afu_req_mdata),
        .alloc_idx(alloc_idx),
        .enq_en(enq_en),
        .enq_idx(enq_idx),
        .enq_data(enq_data),
        .deq_en(deq_en),
        .not_empty(not_empty),
        .first_data(first_data),
        .first_len(first_len),
        .first_mdata(first_mdata)
    );

    // ==================================================
    // Response capture
    // ==================================================

    logic rsp_rd_q;
    logic rsp_msg_q;
    logic msg_qq;
    t_mdata rsp_mdata_q;
    t_cl_num rsp_cl_num_q;
    t_line_data rsp_data_q;
    t_mdata msg_mdata_qq;
    t_cl_num msg_cl_num_qq;
    t_line_data msg_data_qq;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_rd_q <= 1'b0;
            rsp_msg_q <= 1'b0;
            msg_qq <= 1'b0;
        end
        else
        begin
            rsp_rd_q <= host_rsp_valid && (host_rsp_type == RSP_RDLINE);
            rsp_msg_q <= host_rsp_valid && (host_rsp_type == RSP_MSG);
            msg_qq <= rsp_msg_q;
        end
    end

    // Payload stages; a read beat's slot is its base index plus its beat number
    always_ff @(posedge clk)
    begin
        enq_idx <= t_rob_idx'(host_rsp_mdata) + t_rob_idx'(host_rsp_cl_num);
        rsp_mdata_q <= host_rsp_mdata;
        rsp_cl_num_q <= host_rsp_cl_num;
        rsp_data_q <= host_rsp_data;
        msg_mdata_qq <= rsp_mdata_q;
        msg_cl_num_qq <= rsp_cl_num_q;
        msg_data_qq <= rsp_data_q;
    end

    assign enq_en = rsp_rd_q;
    assign enq_data = rsp_data_q;

    // ==================================================
    // In-order dequeue
    // ==================================================

    logic deq_q;
    logic rd_rdy;

    // A message arriving now owns the output slot two cycles later,
    // so the buffer holds back for exactly that cycle
    assign deq_en = not_empty && !(host_rsp_valid && (host_rsp_type == RSP_MSG));

    // Buffer output is valid two cycles after the dequeue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_q <= 1'b0;
            rd_rdy <= 1'b0;
        end
        else
        begin
            deq_q <= deq_en;
            rd_rdy <= deq_q;
        end
    end

    // ==================================================
    // Packet metadata recovery
    // ==================================================

    logic rd_sop;
    logic rd_eop;
    t_cl_num rd_cl_num;
    t_cl_num rd_len;
    t_mdata rd_mdata;
    t_cl_num sop_len;
    t_mdata sop_mdata;

    // Only the base entry holds valid metadata, later beats reuse the latched copy
    always_comb
    begin
        if (rd_sop)
        begin
            rd_len = first_len;
            rd_mdata = first_mdata;
        end
        else
        begin
            rd_len = sop_len;
            rd_mdata = sop_mdata;
        end
    end

    assign rd_eop = (rd_cl_num == rd_len);

    // The beat counter restarts after each last beat, and a new packet follows
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_sop <= 1'b1;
            rd_cl_num <= '0;
        end
        else if (rd_rdy)
        begin
            rd_sop <= rd_eop;
            rd_cl_num <= rd_eop ? t_cl_num'(0) : rd_cl_num + t_cl_num'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_rdy && rd_sop)
        begin
            sop_len <= first_len;
            sop_mdata <= first_mdata;
        end
    end

    // ==================================================
    // Output merge and credit return
    // ==================================================

    // Dequeue suppression keeps both sources from ever sharing a cycle
    always_comb
    begin
        if (rd_rdy)
        begin
            afu_rsp_type = RSP_RDLINE;
            afu_rsp_mdata = rd_mdata;
            afu_rsp_cl_num = rd_cl_num;
            afu_rsp_data = first_data;
        end
        else
        begin
            afu_rsp_type = RSP_MSG;
            afu_rsp_mdata = msg_mdata_qq;
            afu_rsp_cl_num = msg_cl_num_qq;
            afu_rsp_data = msg_data_qq;
        end
    end

    assign afu_rsp_valid = rd_rdy || msg_qq;

    // Each delivered read beat frees one line, so one credit goes back
    assign afu_credit_return = rd_rdy;

endmodule

//--- verilog/rd_rob.sv
// Reorder buffer: tail and head pointers, per-entry arrival bits, data and metadata arrays
`timescale 1ns/10ps
`include "rd_rob_cfg.svh"

module rd_rob
(
    input  logic                    clk,
    input  logic                    reset,

    // Allocation of one to four consecutive lines for a new request
    input  logic [2:0]              alloc_n,
    input  rd_rob_pkg::t_cl_num     alloc_meta_len,
    input  rd_rob_pkg::t_mdata      alloc_meta_mdata,
    output rd_rob_pkg::t_rob_idx    alloc_idx,

    // Arrival of one beat from the host
    input  logic                    enq_en,
    input  rd_rob_pkg::t_rob_idx    enq_idx,
    input  rd_rob_pkg::t_line_data  enq_data,

    // In-order removal at the head
    input  logic                    deq_en,
    output logic                    not_empty,

    // Head entry contents, two cycles after deq_en
    output rd_rob_pkg::t_line_data  first_data,
    output rd_rob_pkg::t_cl_num     first_len,
    output rd_rob_pkg::t_mdata      first_mdata
);
    import rd_rob_pkg::*;

    localparam int N_META_BITS = $bits(t_cl_num) + $bits(t_mdata);
    localparam int CNT_W = $clog2(`RD_ROB_ENTRIES) + 1;

    // Occupancy counter, wide enough to hold a completely full buffer
    typedef logic [CNT_W-1:0] t_count;

    // ==================================================
    // Pointers and arrival bits
    // ==================================================

    t_rob_idx tail;
    t_rob_idx head;
    t_count n_used;

    // One bit per line, set when its beat has been written
    logic [`RD_ROB_ENTRIES-1:0] arrived;

    // A new request always starts at the current tail
    assign alloc_idx = tail;

    // The head may leave only once its own beat is present
    assign not_empty = arrived[head];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail <= '0;
            head <= '0;
            n_used <= '0;
            arrived <= '0;
        end
        else
        begin
            // Zero lines requested leaves the tail where it is
            tail <= tail + t_rob_idx'(alloc_n);
            n_used <= n_used + t_count'(alloc_n) - t_count'(deq_en);

            if (enq_en)
            begin
                arrived[enq_idx] <= 1'b1;
            end

            // The head entry is never the enqueue target in the same cycle
            if (deq_en)
            begin
                arrived[head] <= 1'b0;
                head <= head + t_rob_idx'(1);
            end
        end
    end

    // ==================================================
    // Storage arrays
    // ==================================================

    // Beat data, written at base plus beat number
    rob_ram
    #(
        .N_DATA_BITS($bits(t_line_data))
    )
    i_data_ram
    (
        .clk(clk),
        .wr_en(enq_en),
        .wr_idx(enq_idx),
        .wr_data(enq_data),
        .rd_en(deq_en),
        .rd_idx(head),
        .rd_data(first_data)
    );

    // Length and tag, written only at the base entry of a request
    // Reads at later entries return stale words, the shim ignores them
    rob_ram
    #(
        .N_DATA_BITS(N_META_BITS)
    )
    i_meta_ram
    (
        .clk(clk),
        .wr_en(alloc_n != 3'd0),
        .wr_idx(tail),
        .wr_data({alloc_meta_len, alloc_meta_mdata}),
        .rd_en(deq_en),
        .rd_idx(head),
        .rd_data({first_len, first_mdata})
    );

    // ==================================================
    // Checks
    // ==================================================

    // Credits held by the accelerator must keep every request within the free lines
    a_alloc_space: assert property (@(posedge clk) disable iff (reset)
        (t_count'(alloc_n) <= t_count'(`RD_ROB_ENTRIES) - n_used) &&
        (alloc_n <= 3'(`MAX_LINES_PER_REQ)))
        else $error("rd_rob: allocation of %0d lines overruns free space", alloc_n);

    // A host beat may land only once per allocation of its line
    a_enq_fresh: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> !arrived[enq_idx])
        else $error("rd_rob: beat written twice at index %0d", enq_idx);

    // The shim must only dequeue an entry whose beat has arrived
    a_deq_ready: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("rd_rob: dequeue while head entry is missing");

endmodule

//--- verilog/rob_ram.sv
// Simple dual-port storage array with a registered address and a registered read output
`timescale 1ns/10ps
`include "rd_rob_cfg.svh"

module rob_ram
#(
    parameter int N_DATA_BITS = 64
)
(
    input  logic                    clk,

    // Write port
    input  logic                    wr_en,
    input  rd_rob_pkg::t_rob_idx    wr_idx,
    input  logic [N_DATA_BITS-1:0]  wr_data,

    // Read port, data appears two cycles after rd_en
    input  logic                    rd_en,
    input  rd_rob_pkg::t_rob_idx    rd_idx,
    output logic [N_DATA_BITS-1:0]  rd_data
);
    import rd_rob_pkg::*;

    // One word per buffer line
    logic [N_DATA_BITS-1:0] mem [`RD_ROB_ENTRIES];

    // Read address captured in the first cycle of a read
    t_rob_idx rd_idx_q;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_data;
        end
    end

    // First read stage holds the address until the array is looked up
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_idx_q <= rd_idx;
        end
    end

    // Second read stage registers the array output
    // It loads every cycle and so holds the last read word between reads
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_idx_q];
    end

endmodule

//--- verilog/rd_rob_pkg.sv
// Shared types: index, tag, address, data and beat-number vectors, response-type enum
`include "rd_rob_cfg.svh"

package rd_rob_pkg;

    // ==================================================
    // Vector types
    // ==================================================

    // Index of one buffer line
    typedef logic [$clog2(`RD_ROB_ENTRIES)-1:0] t_rob_idx;

    // Tag the accelerator attaches to a request and expects back on every beat
    typedef logic [`MDATA_WIDTH-1:0] t_mdata;

    // Line address of a request
    typedef logic [`LINE_ADDR_WIDTH-1:0] t_line_addr;

    // Payload of one beat
    typedef logic [`LINE_DATA_WIDTH-1:0] t_line_data;

    // Beat number within a request
    // The request length field uses the same type and holds lines minus one
    typedef logic [1:0] t_cl_num;

    // ==================================================
    // Response type
    // ==================================================

    // Read beats go through the buffer, messages bypass it
    typedef enum logic {
        RSP_RDLINE = 1'b0,
        RSP_MSG    = 1'b1
    } t_rsp_type;

endpackage

//--- include/rd_rob_cfg.svh
// Sizing macros: buffer depth, beat data, mdata and address widths, lines per request
`ifndef RD_ROB_CFG_SVH
`define RD_ROB_CFG_SVH

// ==================================================
// Reorder buffer sizing
// ==================================================

// Number of buffer lines, which is also the credit count the accelerator starts with
// Must be a power of two so that index arithmetic wraps for free
`define RD_ROB_ENTRIES 32

// Upper bound on lines in one request, set by the two-bit length field
`define MAX_LINES_PER_REQ 4

// ==================================================
// Channel field widths
// ==================================================

// Bits in one response beat
`define LINE_DATA_WIDTH 64

// Bits in the accelerator's own request tag
`define MDATA_WIDTH 16

// Bits in a line address
`define LINE_ADDR_WIDTH 32

`endif
